// ==== design/audio_accum.sv ====
// Frame accumulator
// Sums the held sample on every clock of a frame and yields
// the frame average one cycle after the frame start

module audio_accum #(
  parameter int FRAME_BITS = 7
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic [audio_pkg::SAMPLE_W-1:0] sample_i,
  input  logic                           frame_start_i,
  output logic [audio_pkg::SAMPLE_W-1:0] avg_o,
  output logic                           avg_valid_o
);
  import audio_pkg::*;

  // Room for 2^FRAME_BITS full-scale samples
  localparam int ACC_W = SAMPLE_W + FRAME_BITS;

  logic [ACC_W-1:0] acc_q;
  logic [ACC_W-1:0] sample_ext;

  assign sample_ext = {{FRAME_BITS{1'b0}}, sample_i};

  ////////////////////////////////////////
  // Sum and restart
  ////////////////////////////////////////

  // At frame start the sum covers phases 0 to the last phase of
  // the previous frame; the new sum starts with the current sample
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      acc_q       <= '0;
      avg_valid_o <= 1'b0;
    end else begin
      avg_valid_o <= frame_start_i;
      if (frame_start_i) begin
        acc_q <= sample_ext;
      end else begin
        acc_q <= acc_q + sample_ext;
      end
    end
  end

  // Divide by the frame length
  always_ff @(posedge clk_i) begin
    if (frame_start_i) begin
      avg_o <= acc_q[ACC_W-1:FRAME_BITS];
    end
  end

endmodule

// ==== design/audio_clkgen.sv ====
// Audio timing generator
// Free-running divider for the DAC clocks, the frame phase,
// a frame-start strobe and a slow heartbeat

module audio_clkgen #(
  parameter int FRAME_BITS = 7
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  output logic [FRAME_BITS-1:0] phase_o,
  output logic                  frame_start_o,
  output logic                  sysck_o,
  output logic                  bck_o,
  output logic                  lrclk_o,
  output logic                  heartbeat_o
);

  localparam int CNT_W = 23;

  logic [CNT_W-1:0] cnt_q;
  logic             wrap;

  // Last phase of the frame, the strobe lands on phase 0
  assign wrap = (cnt_q[FRAME_BITS-1:0] == '1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q         <= '0;
      frame_start_o <= 1'b0;
    end else begin
      cnt_q         <= cnt_q + 1'b1;
      frame_start_o <= wrap;
    end
  end

  ////////////////////////////////////////
  // Clock taps
  ////////////////////////////////////////

  assign phase_o = cnt_q[FRAME_BITS-1:0];

  // System clock is half the core clock
  assign sysck_o = cnt_q[0];

  // One bit lasts four clocks
  assign bck_o = cnt_q[1];

  // Low for left, high for right
  assign lrclk_o = cnt_q[FRAME_BITS-1];

  // Visible blink rate
  assign heartbeat_o = cnt_q[CNT_W-1];

endmodule

// ==== design/audio_dac_top.sv ====
// Audio output path top level
// Wishbone register slave, DAC timing, frame averaging and
// serial data line for an external audio DAC

module audio_dac_top #(
  parameter int FRAME_BITS = 7
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           cyc_i,
  input  logic                           stb_i,
  input  logic                           we_i,
  input  logic [audio_pkg::ADDR_W-1:0]   adr_i,
  input  logic [1:0]                     sel_i,
  input  logic [audio_pkg::SAMPLE_W-1:0] dat_i,
  output logic [audio_pkg::SAMPLE_W-1:0] dat_o,
  output logic                           ack_o,
  output logic                           err_o,
  output logic                           data_o,
  output logic                           sysck_o,
  output logic                           bck_o,
  output logic                           lrclk_o,
  output logic                           heartbeat_o
);
  import audio_pkg::*;

  logic [SAMPLE_W-1:0]   sample;
  logic                  mute;
  logic [FRAME_BITS-1:0] phase;
  logic                  frame_start;
  logic [SAMPLE_W-1:0]   avg_word;
  logic                  avg_valid;
  logic [SAMPLE_W-1:0]   last_word;

  ////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////

  wb_audio_regs u_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cyc_i       (cyc_i),
    .stb_i       (stb_i),
    .we_i        (we_i),
    .adr_i       (adr_i),
    .sel_i       (sel_i),
    .dat_i       (dat_i),
    .dat_o       (dat_o),
    .ack_o       (ack_o),
    .err_o       (err_o),
    .last_word_i (last_word),
    .sample_o    (sample),
    .mute_o      (mute)
  );

  ////////////////////////////////////////
  // DAC side
  ////////////////////////////////////////

  audio_clkgen #(.FRAME_BITS(FRAME_BITS)) u_clkgen (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .phase_o       (phase),
    .frame_start_o (frame_start),
    .sysck_o       (sysck_o),
    .bck_o         (bck_o),
    .lrclk_o       (lrclk_o),
    .heartbeat_o   (heartbeat_o)
  );

  audio_accum #(.FRAME_BITS(FRAME_BITS)) u_accum (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .sample_i      (sample),
    .frame_start_i (frame_start),
    .avg_o         (avg_word),
    .avg_valid_o   (avg_valid)
  );

  audio_serial_fsm #(.FRAME_BITS(FRAME_BITS)) u_serial (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .phase_i     (phase),
    .avg_i       (avg_word),
    .avg_valid_i (avg_valid),
    .mute_i      (mute),
    .data_o      (data_o),
    .last_word_o (last_word)
  );

endmodule

// ==== design/audio_pkg.sv ====
// Audio DAC shared definitions
// Sample width, register map of the Wishbone slave and the
// serializer state encoding

package audio_pkg;

  ////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////

  // PCM sample width
  parameter int SAMPLE_W = 16;

  // Word address width seen by the slave
  parameter int ADDR_W = 2;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  // Held sample, byte-lane writable
  parameter logic [ADDR_W-1:0] REG_SAMPLE = 2'd0;
  // Control, bit 0 is mute
  parameter logic [ADDR_W-1:0] REG_CTRL   = 2'd1;
  // Last word loaded into the serializer, read only
  parameter logic [ADDR_W-1:0] REG_LAST   = 2'd2;

  // Serializer states
  typedef enum logic [1:0] {
    WAIT_FRAME = 2'd0,
    LEFT       = 2'd1,
    RIGHT      = 2'd2
  } ser_state_t;

endpackage

// ==== design/audio_serial_fsm.sv ====
// Serializer for the DAC data line
// Loads the frame average, or zero when muted, and shifts it out
// MSB first in the left and in the right half of each frame

module audio_serial_fsm #(
  parameter int FRAME_BITS = 7
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic [FRAME_BITS-1:0]          phase_i,
  input  logic [audio_pkg::SAMPLE_W-1:0] avg_i,
  input  logic                           avg_valid_i,
  input  logic                           mute_i,
  output logic                           data_o,
  output logic [audio_pkg::SAMPLE_W-1:0] last_word_o
);
  import audio_pkg::*;

  // Position inside one half frame
  localparam int HALF_W = FRAME_BITS - 1;

  ser_state_t          state_q;
  ser_state_t          state_d;
  logic [SAMPLE_W-1:0] buf_q;
  logic [SAMPLE_W-1:0] load_word;
  logic [SAMPLE_W-1:0] cur_word;
  logic                load;
  logic [HALF_W-1:0]   half_pos;
  logic [3:0]          bit_idx;
  logic                in_window;
  logic                active;

  assign load      = avg_valid_i && (state_q != LEFT);
  assign load_word = mute_i ? '0 : avg_i;

  ////////////////////////////////////////
  // Bit select
  ////////////////////////////////////////

  // The average arrives at phase 1, so the new word is passed
  // through during the load cycle; the MSB then settles while
  // bck is still low and holds until the end of phase 3
  assign cur_word = load ? load_word : buf_q;

  assign half_pos  = phase_i[HALF_W-1:0];
  assign bit_idx   = half_pos[5:2];
  // Word uses the first 64 clocks of the half
  assign in_window = ((half_pos >> 6) == '0);
  assign active    = load || (state_q != WAIT_FRAME);

  assign data_o = active && in_window && cur_word[4'(SAMPLE_W - 1) - bit_idx];

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      WAIT_FRAME: begin
        if (avg_valid_i) begin
          state_d = LEFT;
        end
      end
      LEFT: begin
        // Right half begins with lrclk high
        if (phase_i[FRAME_BITS-1]) begin
          state_d = RIGHT;
        end
      end
      RIGHT: begin
        if (avg_valid_i) begin
          state_d = LEFT;
        end
      end
      default: state_d = WAIT_FRAME;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= WAIT_FRAME;
      last_word_o <= '0;
    end else begin
      state_q <= state_d;
      if (load) begin
        last_word_o <= load_word;
      end
    end
  end

  // Word shifted for both halves of the frame
  always_ff @(posedge clk_i) begin
    if (load) begin
      buf_q <= load_word;
    end
  end

endmodule

// ==== design/wb_audio_regs.sv ====
// Wishbone register slave of the audio path
// Holds the PCM sample and the mute bit, reads back the last
// serialized word; classic single-cycle ack, err on unmapped address

module wb_audio_regs (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           cyc_i,
  input  logic                           stb_i,
  input  logic                           we_i,
  input  logic [audio_pkg::ADDR_W-1:0]   adr_i,
  input  logic [1:0]                     sel_i,
  input  logic [audio_pkg::SAMPLE_W-1:0] dat_i,
  output logic [audio_pkg::SAMPLE_W-1:0] dat_o,
  output logic                           ack_o,
  output logic                           err_o,
  input  logic [audio_pkg::SAMPLE_W-1:0] last_word_i,
  output logic [audio_pkg::SAMPLE_W-1:0] sample_o,
  output logic                           mute_o
);
  import audio_pkg::*;

  logic                req;
  logic                mapped;
  logic                wr_sample;
  logic                wr_ctrl;
  logic [SAMPLE_W-1:0] rd_data;

  // A new request only while no response is pending, since the
  // master still holds stb_i during the ack cycle
  assign req = cyc_i && stb_i && !ack_o && !err_o;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  always_comb begin
    mapped  = 1'b1;
    rd_data = '0;
    case (adr_i)
      REG_SAMPLE: rd_data = sample_o;
      REG_CTRL:   rd_data = {{(SAMPLE_W-1){1'b0}}, mute_o};
      REG_LAST:   rd_data = last_word_i;
      default:    mapped  = 1'b0;
    endcase
  end

  assign wr_sample = req && we_i && (adr_i == REG_SAMPLE);
  assign wr_ctrl   = req && we_i && (adr_i == REG_CTRL);

  // Sample with byte lanes, mute bit from lane 0
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sample_o <= '0;
      mute_o   <= 1'b0;
    end else begin
      if (wr_sample && sel_i[0]) begin
        sample_o[7:0] <= dat_i[7:0];
      end
      if (wr_sample && sel_i[1]) begin
        sample_o[SAMPLE_W-1:8] <= dat_i[SAMPLE_W-1:8];
      end
      if (wr_ctrl && sel_i[0]) begin
        mute_o <= dat_i[0];
      end
    end
  end

  ////////////////////////////////////////
  // Response
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end else begin
      ack_o <= req && mapped;
      err_o <= req && !mapped;
    end
  end

  // Read data lines up with the ack
  always_ff @(posedge clk_i) begin
    if (req && !we_i) begin
      dat_o <= rd_data;
    end
  end

endmodule

// ==== filelist.f ====
design/audio_pkg.sv
design/wb_audio_regs.sv
design/audio_clkgen.sv
design/audio_accum.sv
design/audio_serial_fsm.sv
design/audio_dac_top.sv
testbench/audio_dac_chk.sv
testbench/audio_dac_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the audio DAC testbench with Verilator, run it and judge the log

rm -rf obj_dir sim.log
verilator --binary --assert --top-module audio_dac_tb -f filelist.f -o audio_dac_sim \
  && ./obj_dir/audio_dac_sim +verilator+error+limit+1000 > sim.log 2>&1
grep -q "TEST RESULT: PASS" sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== testbench/audio_dac_chk.sv ====
// Bound checks for the audio DAC top level
// Wishbone response rules and the quiet tail of each half frame

module audio_dac_chk #(
  parameter int FRAME_BITS = 7
) (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic                  cyc_i,
  input logic                  stb_i,
  input logic                  ack_o,
  input logic                  err_o,
  input logic                  data_o,
  input logic [FRAME_BITS-1:0] phase_i
);

  localparam int HALF = 2 ** (FRAME_BITS - 1);

  // Failed assertion count
  int unsigned fail_cnt = 0;

  logic req;
  logic tail;

  assign req  = cyc_i && stb_i && !ack_o && !err_o;
  // Clocks after the 16 data bits of a half frame
  assign tail = (int'(phase_i) % HALF) >= 64;

  ack_err_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ack_o && err_o)) else begin
    fail_cnt++;
    $error("ack_o and err_o high together");
  end

  response_next_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req |=> (ack_o ^ err_o)) else begin
    fail_cnt++;
    $error("no single response one cycle after the strobe");
  end

  response_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ack_o || err_o) |=> !(ack_o || err_o)) else begin
    fail_cnt++;
    $error("response held longer than one cycle");
  end

  data_low_in_tail: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tail |-> !data_o) else begin
    fail_cnt++;
    $error("data_o high after the word in a half frame");
  end

  // Second clock of bck high, the bit must not have moved
  data_stable_bck_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (phase_i[1:0] == 2'b11) |-> $stable(data_o)) else begin
    fail_cnt++;
    $error("data_o changed while bck_o was high");
  end

endmodule

// ==== testbench/audio_dac_tb.sv ====
// Testbench for the audio DAC output path
// Drives the Wishbone slave from a stimulus table and LFSR samples,
// captures the serial frames and checks words, read-back and clocks

module audio_dac_tb;
  import audio_pkg::*;

  localparam int FRAME_BITS = 7;

  typedef struct packed {
    logic [SAMPLE_W-1:0] sample;
    logic                mute;
    logic [1:0]          sel;
    logic [SAMPLE_W-1:0] exp_left;
    logic [SAMPLE_W-1:0] exp_right;
  } vec_t;

  logic                clk_i;
  logic                rst_n_i;
  logic                cyc_i;
  logic                stb_i;
  logic                we_i;
  logic [ADDR_W-1:0]   adr_i;
  logic [1:0]          sel_i;
  logic [SAMPLE_W-1:0] dat_i;
  logic [SAMPLE_W-1:0] dat_o;
  logic                ack_o;
  logic                err_o;
  logic                data_o;
  logic                sysck_o;
  logic                bck_o;
  logic                lrclk_o;
  logic                heartbeat_o;

  int          tests;
  int          checks;
  int          errors;
  logic [31:0] lfsr_q;

  // Sample, mute, lanes, expected left and right word
  vec_t vectors [5] = '{
    '{16'hA5C3, 1'b0, 2'b11, 16'hA5C3, 16'hA5C3},
    '{16'h1234, 1'b0, 2'b01, 16'hA534, 16'hA534},
    '{16'hFFFF, 1'b1, 2'b11, 16'h0000, 16'h0000},
    '{16'h8001, 1'b0, 2'b11, 16'h8001, 16'h8001},
    '{16'h5A99, 1'b0, 2'b10, 16'h5A01, 16'h5A01}
  };

  audio_dac_top #(.FRAME_BITS(FRAME_BITS)) uut (.*);

  bind audio_dac_top audio_dac_chk #(.FRAME_BITS(FRAME_BITS)) u_chk (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cyc_i   (cyc_i),
    .stb_i   (stb_i),
    .ack_o   (ack_o),
    .err_o   (err_o),
    .data_o  (data_o),
    .phase_i (phase)
  );

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h80200003;
    return s >> 1;
  endfunction

  // Selected DAC clock: 0 bck_o, 1 lrclk_o, 2 sysck_o
  function automatic logic clock_level(input int which);
    case (which)
      1:       return lrclk_o;
      2:       return sysck_o;
      default: return bck_o;
    endcase
  endfunction

  task automatic abort_run(input string what);
    $display("Timeout while waiting for %s", what);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [SAMPLE_W-1:0] exp,
                             input logic [SAMPLE_W-1:0] act);
    checks++;
    assert (act === exp) else begin
      $display("** Error %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic bus_cycle(input logic we, input logic [ADDR_W-1:0] adr, input logic [1:0] sel,
                           input logic [SAMPLE_W-1:0] wdata,
                           output logic [SAMPLE_W-1:0] rdata, output logic got_err);
    int waited;
    @(posedge clk_i);
    #1;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = we;
    adr_i = adr;
    sel_i = sel;
    dat_i = wdata;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > 16) abort_run("a Wishbone response");
    end while (!(ack_o || err_o));
    rdata   = dat_o;
    got_err = err_o;
    @(posedge clk_i);
    #1;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [ADDR_W-1:0] adr, input logic [1:0] sel,
                          input logic [SAMPLE_W-1:0] wdata, output logic got_err);
    logic [SAMPLE_W-1:0] unused;
    bus_cycle(1'b1, adr, sel, wdata, unused, got_err);
  endtask

  task automatic wb_read(input logic [ADDR_W-1:0] adr, output logic [SAMPLE_W-1:0] rdata,
                         output logic got_err);
    bus_cycle(1'b0, adr, 2'b11, '0, rdata, got_err);
  endtask

  // Edges are seen on the falling clock, where the outputs are settled
  task automatic wait_edge(input int which, input logic rising, input int limit,
                           input string what, output int waited);
    logic prev;
    logic cur;
    logic found;
    prev   = clock_level(which);
    found  = 1'b0;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      cur   = clock_level(which);
      found = (cur == rising) && (prev != rising);
      prev  = cur;
      if (!found && waited >= limit) abort_run(what);
    end while (!found);
  endtask

  task automatic capture_frame(output logic [SAMPLE_W-1:0] left,
                               output logic [SAMPLE_W-1:0] right);
    int n;
    int i;
    wait_edge(1'b1, 1'b1, 512, "lrclk_o rising", n);
    wait_edge(1'b1, 1'b0, 512, "lrclk_o falling", n);
    for (i = 0; i < SAMPLE_W; i++) begin
      wait_edge(1'b0, 1'b1, 8, "bck_o rising", n);
      left = {left[SAMPLE_W-2:0], data_o};
    end
    wait_edge(1'b1, 1'b1, 512, "lrclk_o rising", n);
    for (i = 0; i < SAMPLE_W; i++) begin
      wait_edge(1'b0, 1'b1, 8, "bck_o rising", n);
      right = {right[SAMPLE_W-2:0], data_o};
    end
  endtask

  task automatic run_frame_test(input vec_t v);
    logic [SAMPLE_W-1:0] rdata;
    logic [SAMPLE_W-1:0] left;
    logic [SAMPLE_W-1:0] right;
    logic                got_err;
    int                  n;
    wb_write(REG_CTRL, 2'b11, {{(SAMPLE_W-1){1'b0}}, v.mute}, got_err);
    wb_write(REG_SAMPLE, v.sel, v.sample, got_err);
    // New sample fills the next frame and is shifted in the one after
    wait_edge(1'b1, 1'b0, 512, "lrclk_o falling", n);
    wait_edge(1'b1, 1'b0, 512, "lrclk_o falling", n);
    capture_frame(left, right);
    check_value("data_o left word", v.exp_left, left);
    check_value("data_o right word", v.exp_right, right);
    wb_read(REG_LAST, rdata, got_err);
    check_value("REG_LAST", v.exp_left, rdata);
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests++;
    $display("test %-18s %s", name, (errors == start_errors) ? "ok" : "FAILED");
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial begin
    logic [SAMPLE_W-1:0] rdata;
    logic [SAMPLE_W-1:0] s;
    logic                got_err;
    int                  start;
    int                  n;
    int                  i;
    int                  b;
    clk_i   = 1'b0;
    rst_n_i = 1'b0;
    cyc_i   = 1'b0;
    stb_i   = 1'b0;
    we_i    = 1'b0;
    adr_i   = '0;
    sel_i   = '0;
    dat_i   = '0;
    tests   = 0;
    checks  = 0;
    errors  = 0;
    lfsr_q  = 32'h9e79ca51;
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    start = errors;
    @(negedge clk_i);
    check_value("ack_o", 16'h0, 16'(ack_o));
    check_value("err_o", 16'h0, 16'(err_o));
    check_value("data_o", 16'h0, 16'(data_o));
    check_value("sysck_o", 16'h0, 16'(sysck_o));
    check_value("bck_o", 16'h0, 16'(bck_o));
    check_value("lrclk_o", 16'h0, 16'(lrclk_o));
    check_value("heartbeat_o", 16'h0, 16'(heartbeat_o));
    wb_read(REG_CTRL, rdata, got_err);
    check_value("REG_CTRL", 16'h0000, rdata);
    wb_read(REG_LAST, rdata, got_err);
    check_value("REG_LAST", 16'h0000, rdata);
    report_test("reset state", start);

    start = errors;
    wb_write(REG_SAMPLE, 2'b11, 16'hBEEF, got_err);
    wb_read(REG_SAMPLE, rdata, got_err);
    check_value("REG_SAMPLE", 16'hBEEF, rdata);
    wb_write(REG_SAMPLE, 2'b01, 16'h1234, got_err);
    wb_read(REG_SAMPLE, rdata, got_err);
    check_value("REG_SAMPLE low lane", 16'hBE34, rdata);
    wb_read(2'd3, rdata, got_err);
    check_value("err_o on address 3", 16'h0001, 16'(got_err));
    report_test("register access", start);

    for (i = 0; i < 5; i++) begin
      start = errors;
      run_frame_test(vectors[i]);
      report_test($sformatf("table entry %0d", i), start);
    end

    for (i = 0; i < 8; i++) begin
      start = errors;
      s = '0;
      for (b = 0; b < SAMPLE_W; b++) begin
        s = {s[SAMPLE_W-2:0], lfsr_q[0]};
        lfsr_q = lfsr_next(lfsr_q);
      end
      run_frame_test('{s, 1'b0, 2'b11, s, s});
      report_test($sformatf("lfsr sample %0d", i), start);
    end

    start = errors;
    wait_edge(1'b1, 1'b1, 512, "lrclk_o rising", n);
    wait_edge(1'b1, 1'b1, 512, "lrclk_o rising", n);
    check_value("lrclk_o period", 16'h0080, 16'(n));
    wait_edge(1'b0, 1'b1, 8, "bck_o rising", n);
    wait_edge(1'b0, 1'b1, 8, "bck_o rising", n);
    check_value("bck_o period", 16'h0004, 16'(n));
    wait_edge(2, 1'b1, 4, "sysck_o rising", n);
    wait_edge(2, 1'b1, 4, "sysck_o rising", n);
    check_value("sysck_o period", 16'h0002, 16'(n));
    // Heartbeat stays low for the first 2^22 clocks
    check_value("heartbeat_o", 16'h0000, 16'(heartbeat_o));
    report_test("clock periods", start);

    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests, checks, errors, uut.u_chk.fail_cnt);
    if (errors == 0 && uut.u_chk.fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
